// File: Makefile
VERILATOR ?= verilator
TOP       ?= ftq_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard include/*.svh design/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/ftq_entry_store.sv
`timescale 1ns/1ps
`include "ftq_cfg.svh"

module ftq_entry_store
    import ftq_pkg::*;
(
    input  logic         clk,

    // prediction block from the BPU
    input  addr_t        i_pred_start,
    input  addr_t        i_pred_end,
    input  addr_t        i_pred_next,
    input  addr_t        i_pred_target,
    input  logic         i_pred_taken,
    input  branch_type_e i_pred_type,

    // backend read port
    input  ftq_idx_t     i_rd_idx,
    output addr_t        o_rd_start,
    output addr_t        o_rd_next,

    // branch writeback
    input  logic         i_wb_vld,
    input  logic         i_wb_mispred,
    input  logic         i_wb_taken,
    input  ftq_idx_t     i_wb_idx,
    input  blk_ofs_t     i_wb_ofs,
    input  addr_t        i_wb_target,
    input  branch_type_e i_wb_type,

    // icache side
    output ftq_idx_t     o_fetch_idx,
    output addr_t        o_fetch_start,
    output addr_t        o_fetch_next,
    output blk_ofs_t     o_fetch_size,
    output logic         o_fetch_taken,

    // predictor update from the head entry
    output addr_t        o_upd_start,
    output addr_t        o_upd_fallthru,
    output addr_t        o_upd_target,
    output branch_type_e o_upd_type,
    output logic         o_upd_taken,
    output logic         o_upd_mispred,

    ftq_ptr_if.store     p
);

    fetch_entry_t fetch_mem [`FTQ_DEPTH];
    br_entry_t    br_mem    [`FTQ_DEPTH];

    // set by a backend writeback, cleared on push and on retire
    logic [`FTQ_DEPTH-1:0] wb_done;

    blk_ofs_t     pred_size;
    fetch_entry_t pred_entry;
    br_entry_t    pred_br;
    fetch_entry_t fetch_sel;
    fetch_entry_t head_entry;
    br_entry_t    head_br;
    addr_t        rd_start_q;
    addr_t        rd_next_q;

    // end is the fall-through address, so this is the byte count
    assign pred_size = blk_ofs_t'(i_pred_end - i_pred_start);

    assign pred_entry = '{
        start_pc: i_pred_start,
        size:     pred_size,
        taken:    i_pred_taken,
        next_pc:  i_pred_next
    };

    // predicted branch info until the backend reports back
    assign pred_br = '{
        mispred: 1'b0,
        taken:   i_pred_taken,
        ofs:     pred_size,
        target:  i_pred_target,
        btype:   i_pred_type
    };

    always_ff @(posedge clk) begin
        if (p.push) begin
            fetch_mem[p.pred_ptr] <= pred_entry;
            br_mem[p.pred_ptr]    <= pred_br;
            wb_done[p.pred_ptr]   <= 1'b0;
        end
        if (p.pop) begin
            wb_done[p.commit_ptr] <= 1'b0;
        end
        // later than push so the backend copy wins
        if (i_wb_vld) begin
            br_mem[i_wb_idx] <= '{
                mispred: i_wb_mispred,
                taken:   i_wb_taken,
                ofs:     i_wb_ofs,
                target:  i_wb_target,
                btype:   i_wb_type
            };
            wb_done[i_wb_idx] <= 1'b1;
        end
        rd_start_q <= fetch_mem[i_rd_idx].start_pc;
        rd_next_q  <= fetch_mem[i_rd_idx].next_pc;
    end

    assign o_rd_start = rd_start_q;
    assign o_rd_next  = rd_next_q;

    // bypass only happens with fetch_ptr == pred_ptr, so the index needs no mux
    assign fetch_sel = p.bypass ? pred_entry : fetch_mem[p.fetch_ptr];

    assign o_fetch_idx   = p.fetch_ptr;
    assign o_fetch_start = fetch_sel.start_pc;
    assign o_fetch_next  = fetch_sel.next_pc;
    assign o_fetch_size  = fetch_sel.size;
    assign o_fetch_taken = fetch_sel.taken;

    assign head_entry = fetch_mem[p.commit_ptr];
    assign head_br    = br_mem[p.commit_ptr];

    assign o_upd_start    = head_entry.start_pc;
    assign o_upd_fallthru = head_entry.start_pc + addr_t'(head_br.ofs);
    assign o_upd_target   = head_br.target;
    assign o_upd_type     = head_br.btype;
    assign o_upd_taken    = head_br.taken;
    assign o_upd_mispred  = head_br.mispred;

    assign p.commit_is_branch = (head_br.btype != BR_NONE);

    // one resolution per block from the backend
    ap_wb_once: assert property (@(posedge clk)
        i_wb_vld |-> !wb_done[i_wb_idx])
        else $error("second writeback to one entry");

endmodule

// File: design/ftq_pkg.sv
`include "ftq_cfg.svh"

package ftq_pkg;

    typedef logic [`FTQ_ADDR_W-1:0] addr_t;
    typedef logic [`FTQ_IDX_W-1:0] ftq_idx_t;

    // index with the wrap flag on top
    typedef logic [`FTQ_IDX_W:0] ftq_ptr_t;

    typedef logic [`FTQ_OFS_W-1:0] blk_ofs_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_COND = 3'd1,
        BR_JAL  = 3'd2,
        BR_JALR = 3'd3,
        BR_CALL = 3'd4,
        BR_RET  = 3'd5
    } branch_type_e;

    // what the icache needs for one block
    typedef struct packed {
        addr_t    start_pc;
        blk_ofs_t size;
        logic     taken;
        addr_t    next_pc;
    } fetch_entry_t;

    // branch fields start as predicted and get replaced by writeback
    typedef struct packed {
        logic         mispred;
        logic         taken;
        blk_ofs_t     ofs;
        addr_t        target;
        branch_type_e btype;
    } br_entry_t;

endpackage

// File: design/ftq_ptr_ctrl.sv
`timescale 1ns/1ps
`include "ftq_cfg.svh"

module ftq_ptr_ctrl
    import ftq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_pred_req,
    input  logic     i_fetch_rdy,
    input  logic     i_commit_vld,
    input  ftq_idx_t i_commit_idx,
    input  logic     i_squash_vld,
    input  logic     i_bpu_update_finished,
    output logic     o_ftq_rdy,
    output logic     o_fetch_req,
    output logic     o_bpu_commit,
    ftq_ptr_if.ctrl  p
);

    localparam int IDX_W = `FTQ_IDX_W;

    ftq_ptr_t pred_q;
    ftq_ptr_t fetch_q;
    ftq_ptr_t commit_q;
    ftq_idx_t thre_q;
    ftq_idx_t thre_nxt;

    logic [`FTQ_DEPTH-1:0] vld_q;
    logic [`FTQ_DEPTH-1:0] vld_nxt;

    logic full;
    logic empty;
    logic unfetched;
    logic do_commit;
    logic push;
    logic pop;
    logic bypass;
    logic fetch_adv;
    logic squash_flip;

    // equal indices with differing wrap flags mean full
    assign full  = (pred_q[IDX_W-1:0] == commit_q[IDX_W-1:0]) &&
                   (pred_q[IDX_W] != commit_q[IDX_W]);
    assign empty = (pred_q == commit_q);

    // fetch lags prediction by at least one block
    assign unfetched = (fetch_q != pred_q);

    // no accept while the pointers are being rewound
    assign o_ftq_rdy = !full && !i_squash_vld;
    assign push      = i_pred_req && o_ftq_rdy;
    assign bypass    = push && !unfetched;

    assign o_fetch_req = unfetched || bypass;
    assign fetch_adv   = o_fetch_req && i_fetch_rdy;

    // retire walks toward the threshold
    // branches also wait on the predictor
    assign do_commit    = (commit_q[IDX_W-1:0] != thre_q);
    assign o_bpu_commit = do_commit && p.commit_is_branch;
    assign pop          = do_commit && (!p.commit_is_branch || i_bpu_update_finished);

    assign thre_nxt = i_commit_vld ? i_commit_idx : thre_q;

    // threshold below the head index means it has wrapped past the end
    assign squash_flip = (thre_nxt >= commit_q[IDX_W-1:0]) ? commit_q[IDX_W] :
                                                             !commit_q[IDX_W];

    always_comb begin
        vld_nxt = vld_q;
        if (i_squash_vld) begin
            for (int i = 0; i < `FTQ_DEPTH; i++) begin
                // keep only commit_ptr up to the threshold
                if (commit_q[IDX_W-1:0] <= thre_nxt) begin
                    if (!((i >= commit_q[IDX_W-1:0]) && (i < thre_nxt))) begin
                        vld_nxt[i] = 1'b0;
                    end
                end else begin
                    if (!((i >= commit_q[IDX_W-1:0]) || (i < thre_nxt))) begin
                        vld_nxt[i] = 1'b0;
                    end
                end
            end
        end else if (push) begin
            vld_nxt[pred_q[IDX_W-1:0]] = 1'b1;
        end
        if (pop) begin
            vld_nxt[commit_q[IDX_W-1:0]] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_q   <= '0;
            fetch_q  <= '0;
            commit_q <= '0;
            thre_q   <= '0;
            vld_q    <= '0;
        end else begin
            vld_q  <= vld_nxt;
            thre_q <= thre_nxt;
            if (pop) begin
                commit_q <= commit_q + ftq_ptr_t'(1);
            end
            if (i_squash_vld) begin
                pred_q  <= {squash_flip, thre_nxt};
                fetch_q <= {squash_flip, thre_nxt};
            end else begin
                if (push) begin
                    pred_q <= pred_q + ftq_ptr_t'(1);
                end
                if (fetch_adv) begin
                    fetch_q <= fetch_q + ftq_ptr_t'(1);
                end
            end
        end
    end

    assign p.pred_ptr   = pred_q[IDX_W-1:0];
    assign p.fetch_ptr  = fetch_q[IDX_W-1:0];
    assign p.commit_ptr = commit_q[IDX_W-1:0];
    assign p.push       = push;
    assign p.bypass     = bypass;
    assign p.pop        = pop;

    ap_push_free: assert property (@(posedge clk) disable iff (rst)
        push |-> !vld_q[pred_q[IDX_W-1:0]])
        else $error("push onto a live entry");

    ap_pop_valid: assert property (@(posedge clk) disable iff (rst)
        pop |-> vld_q[commit_q[IDX_W-1:0]])
        else $error("retire of an empty slot");

    // an empty ring must have left no stale valid bit behind
    ap_empty_clean: assert property (@(posedge clk) disable iff (rst)
        empty |-> (vld_q == '0))
        else $error("valid bit set while queue is empty");

endmodule

// File: design/ftq_ptr_if.sv
`timescale 1ns/1ps

interface ftq_ptr_if
    import ftq_pkg::*;
();

    ftq_idx_t pred_ptr;
    ftq_idx_t fetch_ptr;
    ftq_idx_t commit_ptr;

    logic push;
    logic bypass;
    logic pop;

    // head entry holds a branch
    logic commit_is_branch;

    modport ctrl (
        output pred_ptr, fetch_ptr, commit_ptr,
        output push, bypass, pop,
        input  commit_is_branch
    );

    modport store (
        input  pred_ptr, fetch_ptr, commit_ptr,
        input  push, bypass, pop,
        output commit_is_branch
    );

endinterface

// File: design/ftq_top.sv
`timescale 1ns/1ps

module ftq_top
    import ftq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // BPU
    input  logic         i_pred_req,
    input  addr_t        i_pred_start,
    input  addr_t        i_pred_end,
    input  logic         i_pred_taken,
    input  addr_t        i_pred_next,
    input  addr_t        i_pred_target,
    input  branch_type_e i_pred_type,
    output logic         o_ftq_rdy,

    // BPU update
    output logic         o_bpu_commit,
    input  logic         i_bpu_update_finished,
    output addr_t        o_upd_start,
    output addr_t        o_upd_fallthru,
    output addr_t        o_upd_target,
    output branch_type_e o_upd_type,
    output logic         o_upd_taken,
    output logic         o_upd_mispred,

    // icache
    output logic         o_fetch_req,
    input  logic         i_fetch_rdy,
    output ftq_idx_t     o_fetch_idx,
    output addr_t        o_fetch_start,
    output addr_t        o_fetch_next,
    output blk_ofs_t     o_fetch_size,
    output logic         o_fetch_taken,

    // backend
    input  ftq_idx_t     i_rd_idx,
    output addr_t        o_rd_start,
    output addr_t        o_rd_next,
    input  logic         i_wb_vld,
    input  ftq_idx_t     i_wb_idx,
    input  logic         i_wb_mispred,
    input  logic         i_wb_taken,
    input  blk_ofs_t     i_wb_ofs,
    input  addr_t        i_wb_target,
    input  branch_type_e i_wb_type,
    input  logic         i_commit_vld,
    input  ftq_idx_t     i_commit_idx,
    input  logic         i_squash_vld
);

    ftq_ptr_if ptr_if ();

    ftq_ptr_ctrl i_ptr_ctrl (
        .clk                   (clk),
        .rst                   (rst),
        .i_pred_req            (i_pred_req),
        .i_fetch_rdy           (i_fetch_rdy),
        .i_commit_vld          (i_commit_vld),
        .i_commit_idx          (i_commit_idx),
        .i_squash_vld          (i_squash_vld),
        .i_bpu_update_finished (i_bpu_update_finished),
        .o_ftq_rdy             (o_ftq_rdy),
        .o_fetch_req           (o_fetch_req),
        .o_bpu_commit          (o_bpu_commit),
        .p                     (ptr_if.ctrl)
    );

    ftq_entry_store i_entry_store (
        .clk            (clk),
        .i_pred_start   (i_pred_start),
        .i_pred_end     (i_pred_end),
        .i_pred_next    (i_pred_next),
        .i_pred_target  (i_pred_target),
        .i_pred_taken   (i_pred_taken),
        .i_pred_type    (i_pred_type),
        .i_rd_idx       (i_rd_idx),
        .o_rd_start     (o_rd_start),
        .o_rd_next      (o_rd_next),
        .i_wb_vld       (i_wb_vld),
        .i_wb_mispred   (i_wb_mispred),
        .i_wb_taken     (i_wb_taken),
        .i_wb_idx       (i_wb_idx),
        .i_wb_ofs       (i_wb_ofs),
        .i_wb_target    (i_wb_target),
        .i_wb_type      (i_wb_type),
        .o_fetch_idx    (o_fetch_idx),
        .o_fetch_start  (o_fetch_start),
        .o_fetch_next   (o_fetch_next),
        .o_fetch_size   (o_fetch_size),
        .o_fetch_taken  (o_fetch_taken),
        .o_upd_start    (o_upd_start),
        .o_upd_fallthru (o_upd_fallthru),
        .o_upd_target   (o_upd_target),
        .o_upd_type     (o_upd_type),
        .o_upd_taken    (o_upd_taken),
        .o_upd_mispred  (o_upd_mispred),
        .p              (ptr_if.store)
    );

endmodule

// File: include/ftq_cfg.svh
`ifndef FTQ_CFG_SVH
`define FTQ_CFG_SVH

// program counter width
`define FTQ_ADDR_W 32

// number of queue entries
// must stay a power of two
`define FTQ_DEPTH 8

// entry index width
// the wrap flag sits one bit above it
`define FTQ_IDX_W $clog2(`FTQ_DEPTH)

// byte offset inside a fetch block
// 7 bits hold a full 64 byte block size
`define FTQ_OFS_W 7

`endif

// File: sources.f
+incdir+include
design/ftq_pkg.sv
design/ftq_ptr_if.sv
design/ftq_ptr_ctrl.sv
design/ftq_entry_store.sv
design/ftq_top.sv
test/ftq_tb.sv

// File: test/ftq_tb.sv
`timescale 1ns/1ps
`include "ftq_cfg.svh"

module ftq_tb
    import ftq_pkg::*;
();

    localparam int DEPTH      = `FTQ_DEPTH;
    localparam int NUM_TESTS  = 7;
    localparam int CLK_PERIOD = 100;
    localparam int unsigned SEED = 32'ha677_4014;

    logic clk;
    logic rst;
    logic i_pred_req, i_pred_taken;
    addr_t i_pred_start, i_pred_end, i_pred_next, i_pred_target;
    branch_type_e i_pred_type;
    logic o_ftq_rdy;
    logic o_bpu_commit, i_bpu_update_finished;
    addr_t o_upd_start, o_upd_fallthru, o_upd_target;
    branch_type_e o_upd_type;
    logic o_upd_taken, o_upd_mispred;
    logic o_fetch_req, i_fetch_rdy, o_fetch_taken;
    ftq_idx_t o_fetch_idx;
    addr_t o_fetch_start, o_fetch_next;
    blk_ofs_t o_fetch_size;
    ftq_idx_t i_rd_idx;
    addr_t o_rd_start, o_rd_next;
    logic i_wb_vld, i_wb_mispred, i_wb_taken;
    ftq_idx_t i_wb_idx;
    blk_ofs_t i_wb_ofs;
    addr_t i_wb_target;
    branch_type_e i_wb_type;
    logic i_commit_vld, i_squash_vld;
    ftq_idx_t i_commit_idx;

    // reference queue with one slot per entry index
    addr_t m_start [DEPTH];
    addr_t m_end   [DEPTH];
    addr_t m_next  [DEPTH];
    logic  m_taken [DEPTH];
    addr_t m_btgt  [DEPTH];
    blk_ofs_t m_bofs [DEPTH];
    branch_type_e m_btype [DEPTH];
    logic m_btaken [DEPTH];
    logic m_bmisp  [DEPTH];
    // free running counters whose value modulo DEPTH is the index
    int m_pred, m_fetch, m_commit;
    ftq_idx_t m_thre;
    int err_cnt;

    ftq_top i_ftq_top (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_idx(input string name, input ftq_idx_t got, input ftq_idx_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ofs(input string name, input blk_ofs_t got, input blk_ofs_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_type(input string name, input branch_type_e got,
                              input branch_type_e exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string what);
        err_cnt++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic drive_block(input branch_type_e bt);
        addr_t base;
        base          = addr_t'($urandom) & ~addr_t'(3);
        i_pred_req    = 1'b1;
        i_pred_start  = base;
        // 4 to 64 bytes per block
        i_pred_end    = base + addr_t'(4 * $urandom_range(16, 1));
        i_pred_taken  = 1'($urandom_range(1, 0));
        i_pred_target = addr_t'($urandom) & ~addr_t'(3);
        i_pred_next   = i_pred_taken ? i_pred_target : i_pred_end;
        i_pred_type   = bt;
    endtask

    // compares every combinational output with the model shortly after the drive
    task automatic check_outputs();
        logic full_e, rdy_e, byp_e, freq_e, pend_e, e_taken;
        addr_t e_start, e_end, e_next;
        int fi, hi;
        #1;
        full_e = (m_pred - m_commit) == DEPTH;
        rdy_e  = !full_e && !i_squash_vld;
        byp_e  = i_pred_req && rdy_e && (m_fetch == m_pred);
        freq_e = (m_fetch != m_pred) || byp_e;
        hi     = m_commit % DEPTH;
        pend_e = ftq_idx_t'(hi) != m_thre;
        check_bit("o_ftq_rdy", o_ftq_rdy, rdy_e);
        check_bit("o_fetch_req", o_fetch_req, freq_e);
        check_bit("o_bpu_commit", o_bpu_commit, pend_e && (m_btype[hi] != BR_NONE));
        if (freq_e) begin
            fi      = m_fetch % DEPTH;
            e_start = byp_e ? i_pred_start : m_start[fi];
            e_end   = byp_e ? i_pred_end : m_end[fi];
            e_next  = byp_e ? i_pred_next : m_next[fi];
            e_taken = byp_e ? i_pred_taken : m_taken[fi];
            check_idx("o_fetch_idx", o_fetch_idx, ftq_idx_t'(fi));
            check_addr("o_fetch_start", o_fetch_start, e_start);
            check_ofs("o_fetch_size", o_fetch_size, blk_ofs_t'(e_end - e_start));
            check_bit("o_fetch_taken", o_fetch_taken, e_taken);
            check_addr("o_fetch_next", o_fetch_next, e_next);
        end
        if (pend_e) begin
            check_addr("o_upd_start", o_upd_start, m_start[hi]);
            check_addr("o_upd_fallthru", o_upd_fallthru, m_start[hi] + addr_t'(m_bofs[hi]));
            check_addr("o_upd_target", o_upd_target, m_btgt[hi]);
            check_type("o_upd_type", o_upd_type, m_btype[hi]);
            check_bit("o_upd_taken", o_upd_taken, m_btaken[hi]);
            check_bit("o_upd_mispred", o_upd_mispred, m_bmisp[hi]);
        end
    endtask

    // advances the model across the next clock edge and waits for the falling edge
    task automatic step_cycle();
        logic full_e, acc, byp, adv, pop_e;
        ftq_idx_t thre_n;
        int hi, pi;
        full_e = (m_pred - m_commit) == DEPTH;
        acc    = i_pred_req && !full_e && !i_squash_vld;
        byp    = acc && (m_fetch == m_pred);
        adv    = ((m_fetch != m_pred) || byp) && i_fetch_rdy;
        hi     = m_commit % DEPTH;
        pop_e  = (ftq_idx_t'(hi) != m_thre) &&
                 ((m_btype[hi] == BR_NONE) || i_bpu_update_finished);
        thre_n = i_commit_vld ? i_commit_idx : m_thre;
        pi     = m_pred % DEPTH;
        if (acc) begin
            m_start[pi]  = i_pred_start;
            m_end[pi]    = i_pred_end;
            m_next[pi]   = i_pred_next;
            m_taken[pi]  = i_pred_taken;
            m_bofs[pi]   = blk_ofs_t'(i_pred_end - i_pred_start);
            m_btgt[pi]   = i_pred_target;
            m_btype[pi]  = i_pred_type;
            m_btaken[pi] = i_pred_taken;
            m_bmisp[pi]  = 1'b0;
        end
        if (i_wb_vld) begin
            m_bofs[i_wb_idx]   = i_wb_ofs;
            m_btgt[i_wb_idx]   = i_wb_target;
            m_btype[i_wb_idx]  = i_wb_type;
            m_btaken[i_wb_idx] = i_wb_taken;
            m_bmisp[i_wb_idx]  = i_wb_mispred;
        end
        if (i_squash_vld) begin
            // rewind to the threshold counted forward from the head
            m_pred  = m_commit + ((int'(thre_n) - hi + DEPTH) % DEPTH);
            m_fetch = m_pred;
        end else begin
            if (acc) m_pred++;
            if (adv) m_fetch++;
        end
        if (pop_e) m_commit++;
        m_thre = thre_n;
        @(negedge clk);
    endtask

    task automatic retire_to(input ftq_idx_t thre, input int cycles);
        i_commit_vld = 1'b1;
        i_commit_idx = thre;
        check_outputs();
        step_cycle();
        i_commit_vld = 1'b0;
        repeat (cycles) begin
            check_outputs();
            step_cycle();
        end
    endtask

    task automatic fill_until_full();
        int accepts;
        accepts     = 0;
        i_fetch_rdy = 1'b0;
        repeat (DEPTH + 2) begin
            drive_block(BR_NONE);
            check_outputs();
            if (o_ftq_rdy) accepts++;
            step_cycle();
        end
        i_pred_req = 1'b0;
        if (accepts != DEPTH) begin
            note_failure($sformatf("queue took %0d blocks before it filled", accepts));
        end
        // a rejected block lands on slot 0 if it is stored at all
        i_rd_idx = '0;
        check_outputs();
        step_cycle();
        check_addr("o_rd_start", o_rd_start, m_start[0]);
        check_addr("o_rd_next", o_rd_next, m_next[0]);
    endtask

    task automatic drain_in_order();
        i_fetch_rdy = 1'b1;
        repeat (DEPTH) begin
            check_outputs();
            step_cycle();
        end
        check_bit("o_fetch_req", o_fetch_req, 1'b0);
    endtask

    task automatic retire_plain_blocks();
        retire_to(ftq_idx_t'(4), 6);
        check_bit("o_ftq_rdy", o_ftq_rdy, 1'b1);
        retire_to(ftq_idx_t'(0), 6);
    endtask

    task automatic bypass_on_empty();
        i_fetch_rdy = 1'b1;
        repeat (4) begin
            drive_block(BR_NONE);
            check_outputs();
            step_cycle();
        end
        i_pred_req = 1'b0;
    endtask

    task automatic read_random_entries();
        ftq_idx_t idx;
        addr_t exp_start;
        addr_t exp_next;
        repeat (6) begin
            idx       = ftq_idx_t'($urandom_range(DEPTH - 1, 0));
            i_rd_idx  = idx;
            exp_start = m_start[idx];
            exp_next  = m_next[idx];
            check_outputs();
            step_cycle();
            check_addr("o_rd_start", o_rd_start, exp_start);
            check_addr("o_rd_next", o_rd_next, exp_next);
        end
    endtask

    task automatic retire_branch_entry();
        int br_idx;
        blk_ofs_t ofs;
        addr_t tgt;
        i_fetch_rdy = 1'b1;
        br_idx      = m_pred % DEPTH;
        drive_block(BR_COND);
        check_outputs();
        step_cycle();
        // backend resolves the branch while a plain block arrives
        drive_block(BR_NONE);
        ofs          = blk_ofs_t'($urandom_range(63, 0));
        tgt          = addr_t'($urandom) & ~addr_t'(3);
        i_wb_vld     = 1'b1;
        i_wb_idx     = ftq_idx_t'(br_idx);
        i_wb_mispred = 1'b1;
        i_wb_taken   = 1'b1;
        i_wb_ofs     = ofs;
        i_wb_target  = tgt;
        i_wb_type    = BR_COND;
        check_outputs();
        step_cycle();
        i_pred_req = 1'b0;
        i_wb_vld   = 1'b0;
        // the head must stop at the branch while the predictor is busy
        retire_to(ftq_idx_t'(m_pred % DEPTH), 8);
        check_bit("o_bpu_commit", o_bpu_commit, 1'b1);
        check_addr("o_upd_fallthru", o_upd_fallthru, m_start[br_idx] + addr_t'(ofs));
        check_addr("o_upd_target", o_upd_target, tgt);
        check_bit("o_upd_mispred", o_upd_mispred, 1'b1);
        i_bpu_update_finished = 1'b1;
        check_outputs();
        step_cycle();
        i_bpu_update_finished = 1'b0;
        repeat (2) begin
            check_outputs();
            step_cycle();
        end
        check_bit("o_bpu_commit", o_bpu_commit, 1'b0);
    endtask

    task automatic squash_to_threshold();
        ftq_idx_t thre;
        i_fetch_rdy = 1'b1;
        repeat (4) begin
            drive_block(BR_NONE);
            check_outputs();
            step_cycle();
        end
        i_pred_req = 1'b0;
        // keep the two oldest blocks and drop the two younger ones
        thre         = ftq_idx_t'((m_commit + 2) % DEPTH);
        i_commit_vld = 1'b1;
        i_commit_idx = thre;
        i_squash_vld = 1'b1;
        check_outputs();
        step_cycle();
        i_commit_vld = 1'b0;
        i_squash_vld = 1'b0;
        check_bit("o_fetch_req", o_fetch_req, 1'b0);
        drive_block(BR_NONE);
        check_outputs();
        check_idx("o_fetch_idx", o_fetch_idx, thre);
        step_cycle();
        i_pred_req = 1'b0;
        repeat (4) begin
            check_outputs();
            step_cycle();
        end
        check_bit("o_ftq_rdy", o_ftq_rdy, 1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        err_cnt  = 0;
        rst      = 1'b1;
        i_pred_req = 1'b0;
        i_pred_start = '0;
        i_pred_end = '0;
        i_pred_next = '0;
        i_pred_target = '0;
        i_pred_taken = 1'b0;
        i_pred_type = BR_NONE;
        i_bpu_update_finished = 1'b0;
        i_fetch_rdy = 1'b0;
        i_rd_idx = '0;
        i_wb_vld = 1'b0;
        i_wb_idx = '0;
        i_wb_mispred = 1'b0;
        i_wb_taken = 1'b0;
        i_wb_ofs = '0;
        i_wb_target = '0;
        i_wb_type = BR_NONE;
        i_commit_vld = 1'b0;
        i_commit_idx = '0;
        i_squash_vld = 1'b0;
        m_pred = 0;
        m_fetch = 0;
        m_commit = 0;
        m_thre = '0;
        for (int i = 0; i < DEPTH; i++) begin
            m_btype[i] = BR_NONE;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_bit("o_ftq_rdy", o_ftq_rdy, 1'b1);
        check_bit("o_fetch_req", o_fetch_req, 1'b0);
        check_bit("o_bpu_commit", o_bpu_commit, 1'b0);
        fill_until_full();
        drain_in_order();
        retire_plain_blocks();
        bypass_on_empty();
        read_random_entries();
        retire_branch_entry();
        squash_to_threshold();
        $display("tests done, error count %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // generous bound of 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
